// File: hw/paged_cpu_consts.svh
`ifndef PAGED_CPU_CONSTS_SVH
`define PAGED_CPU_CONSTS_SVH

`define WORD_W      16   // data and logical address width
`define PAGE_WORDS  70   // words per physical segment
`define RAM_WORDS   490  // seven segments
`define RAM_ADDR_W  9    // physical address width
`define OFS_W       7    // offset inside a page
`define SEG_COUNT   7
`define SEG_W       3
`define LPAGE_W     9    // logical page field of a chain entry
`define REG_COUNT   16
`define REG_IDX_W   4
`define PROG_START  46   // first program word
`define APB_ADDR_W  8

`define OFF_CTRL      8'h00
`define OFF_STATUS    8'h04
`define OFF_RAM_ADDR  8'h08
`define OFF_RAM_DATA  8'h0C
`define OFF_MMU_ENTRY 8'h10
`define OFF_START_SEG 8'h14
`define OFF_REG_BASE  8'h40  // register n at base + 4n

`endif

// File: hw/cpu_isa_pkg.sv
`include "paged_cpu_consts.svh"

package cpu_isa_pkg;

  typedef enum logic [7:0] {
    op_jmp           = 8'd1,   // absolute, value must be even
    op_jmp_plus      = 8'd5,   // forward by value instructions
    op_jmp_minus     = 8'd6,   // backward by value instructions
    op_ram2reg       = 8'd7,   // reg = mem[value]
    op_num2reg_low   = 8'd16,  // reg = value
    op_reg_low_plus  = 8'd18,  // reg += value
    op_reg_low_minus = 8'd20,  // reg -= value
    op_exit          = 8'd30
  } opcode_e;

  typedef enum logic [3:0] {
    st_idle,
    st_map_req,   // one-cycle request to the mapper
    st_map_wait,  // waiting for mapper done
    st_word_op,   // opcode word on ram_rdata
    st_word_val,  // value word on ram_rdata, execute
    st_word_mem   // ram2reg data word on ram_rdata
  } core_state_e;

  typedef enum logic {ms_idle, ms_walk} map_state_e;

  typedef enum logic [1:0] {
    err_none,
    err_wrong_address,
    err_wrong_reg_num,
    err_illegal_opcode
  } error_e;

  typedef struct packed {
    logic                en;
    logic [`WORD_W-1:0]  addr;
    logic [`WORD_W-1:0]  data;
  } ram_wr_t;

  typedef struct packed {
    logic                en;
    logic [`SEG_W-1:0]   seg;    // entry being written
    logic [`SEG_W-1:0]   next;   // self index ends the chain
    logic [`LPAGE_W-1:0] lpage;
  } mmu_entry_wr_t;

endpackage

// File: hw/apb_bus_pkg.sv
`include "paged_cpu_consts.svh"

package apb_bus_pkg;

  typedef struct packed {
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`APB_ADDR_W-1:0] paddr;
    logic [`WORD_W-1:0]     pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [`WORD_W-1:0] prdata;
    logic               pready;
    logic               pslverr;
  } apb_rsp_t;

endpackage

// File: hw/word_ram.sv
`timescale 1ns/100ps
`include "paged_cpu_consts.svh"

module word_ram import cpu_isa_pkg::*; (
  input  logic                   clk,
  input  ram_wr_t                ram_wr,
  input  logic [`RAM_ADDR_W-1:0] raddr,
  output logic [`WORD_W-1:0]     rdata
);

  logic [`WORD_W-1:0] mem [`RAM_WORDS];  // program and data words

  always_ff @(posedge clk) begin
    if (ram_wr.en && ram_wr.addr < `RAM_WORDS) begin  // drop writes past the end
      mem[ram_wr.addr[`RAM_ADDR_W-1:0]] <= ram_wr.data;
    end
    rdata <= mem[raddr];  // data one cycle after the address
  end

endmodule

// File: hw/page_mapper.sv
`timescale 1ns/100ps
`include "paged_cpu_consts.svh"

module page_mapper import cpu_isa_pkg::*; (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic [`SEG_W-1:0]      start_seg,
  input  mmu_entry_wr_t          mmu_wr,
  input  logic                   map_req,
  input  logic [`WORD_W-1:0]     map_laddr,
  output logic                   map_done,
  output logic                   map_miss,
  output logic [`RAM_ADDR_W-1:0] map_paddr
);

  logic [`SEG_W-1:0]   next_seg [`SEG_COUNT];  // chain link per segment
  logic [`LPAGE_W-1:0] lpage    [`SEG_COUNT];  // logical page held by segment
  map_state_e          state;
  logic [`SEG_W-1:0]   pos;        // entry under test
  logic [`SEG_W-1:0]   visits;     // bounds a walk through a looped chain
  logic [`WORD_W-1:0]  page_q;
  logic [`OFS_W-1:0]   offset_q;
  logic [`WORD_W-1:0]  req_page;
  logic [`OFS_W-1:0]   req_offset;
  logic                hit;
  logic                chain_end;

  function automatic logic [`RAM_ADDR_W-1:0] phys(input logic [`SEG_W-1:0] seg,
                                                  input logic [`OFS_W-1:0] ofs);
    phys = `RAM_ADDR_W'(seg) * `RAM_ADDR_W'(`PAGE_WORDS) + `RAM_ADDR_W'(ofs);
  endfunction

  assign req_page   = map_laddr / `WORD_W'(`PAGE_WORDS);
  assign req_offset = `OFS_W'(map_laddr % `WORD_W'(`PAGE_WORDS));
  assign hit        = (`WORD_W'(lpage[pos]) == page_q);
  assign chain_end  = (next_seg[pos] == pos) ||
                      (visits == `SEG_W'(`SEG_COUNT - 1));  // every segment seen once

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int s = 0; s < `SEG_COUNT; s++) begin
        next_seg[s] <= `SEG_W'(s);  // each entry starts self-linked
        lpage[s]    <= '0;
      end
    end else if (mmu_wr.en && mmu_wr.seg < `SEG_COUNT && mmu_wr.next < `SEG_COUNT) begin
      next_seg[mmu_wr.seg] <= mmu_wr.next;
      lpage[mmu_wr.seg]    <= mmu_wr.lpage;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= ms_idle;
      pos       <= '0;
      visits    <= '0;
      page_q    <= '0;
      offset_q  <= '0;
      map_done  <= 1'b0;
      map_miss  <= 1'b0;
      map_paddr <= '0;
    end else begin
      map_done <= 1'b0;  // done and miss are single-cycle pulses
      map_miss <= 1'b0;
      case (state)
        ms_idle: begin
          if (map_req) begin
            page_q   <= req_page;
            offset_q <= req_offset;
            if (req_page == '0) begin  // page 0 always sits in the start segment
              map_done  <= 1'b1;
              map_paddr <= phys(start_seg, req_offset);
            end else begin
              pos    <= next_seg[start_seg];  // walk begins after the start entry
              visits <= '0;
              state  <= ms_walk;
            end
          end
        end
        ms_walk: begin
          if (hit) begin
            map_done  <= 1'b1;
            map_paddr <= phys(pos, offset_q);
            state     <= ms_idle;
          end else if (chain_end) begin
            map_done <= 1'b1;
            map_miss <= 1'b1;  // page not in this chain
            state    <= ms_idle;
          end else begin
            pos    <= next_seg[pos];
            visits <= visits + 1'b1;
          end
        end
        default: state <= ms_idle;
      endcase
    end
  end

endmodule

// File: hw/cpu_core.sv
`timescale 1ns/100ps
`include "paged_cpu_consts.svh"

module cpu_core import cpu_isa_pkg::*; (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   start,
  input  logic [`SEG_W-1:0]      start_seg,
  input  logic [`REG_IDX_W-1:0]  reg_ridx,
  input  logic                   map_done,
  input  logic                   map_miss,
  input  logic [`RAM_ADDR_W-1:0] map_paddr,
  input  logic [`WORD_W-1:0]     ram_rdata,
  output logic                   busy,
  output logic                   halted,
  output error_e                 error,
  output logic [`WORD_W-1:0]     reg_rdata,
  output logic                   map_req,
  output logic [`WORD_W-1:0]     map_laddr,
  output logic [`RAM_ADDR_W-1:0] ram_raddr
);

  core_state_e           state;
  core_state_e           after_map;  // stage entered when the mapped word arrives
  logic [`WORD_W-1:0]    pc;         // address of the current instruction
  logic [`WORD_W-1:0]    instr;      // opcode in 15:8, operand in 7:0
  logic [`WORD_W-1:0]    regs [`REG_COUNT];
  opcode_e               op;
  logic [7:0]            operand;
  logic [`REG_IDX_W-1:0] ridx;
  logic                  reg_bad;
  logic [`WORD_W-1:0]    seq_pc;
  logic [`WORD_W+1:0]    back_pc;    // two extra bits show underflow
  logic [`WORD_W-1:0]    target;
  logic [`WORD_W-1:0]    alu_res;
  error_e                exec_err;
  logic                  exec_exit;
  logic                  reg_wr;

  assign op        = opcode_e'(instr[15:8]);
  assign operand   = instr[7:0];
  assign ridx      = operand[`REG_IDX_W-1:0];
  assign reg_bad   = operand >= `REG_COUNT;
  assign seq_pc    = pc + `WORD_W'(2);  // instructions are two words
  assign back_pc   = {2'b00, seq_pc} - {1'b0, ram_rdata, 1'b0};
  assign map_req   = (state == st_map_req);
  assign ram_raddr = map_paddr;  // mapper holds the address through the read
  assign reg_rdata = regs[reg_ridx];  // register read port for the bus

  // execute decode, ram_rdata is the value word in st_word_val
  always_comb begin
    exec_err  = err_none;
    exec_exit = 1'b0;
    reg_wr    = 1'b0;
    target    = seq_pc;
    alu_res   = ram_rdata;
    case (op)
      op_jmp: begin
        if (ram_rdata[0]) begin
          exec_err = err_wrong_address;  // odd target
        end else begin
          target = ram_rdata;
        end
      end
      op_jmp_plus: target = seq_pc + {ram_rdata[`WORD_W-2:0], 1'b0};
      op_jmp_minus: begin
        if (back_pc[`WORD_W+1] || back_pc < `PROG_START) begin
          exec_err = err_wrong_address;  // would land before the program
        end else begin
          target = back_pc[`WORD_W-1:0];
        end
      end
      op_num2reg_low, op_reg_low_plus, op_reg_low_minus: begin
        if (reg_bad) begin
          exec_err = err_wrong_reg_num;
        end else begin
          reg_wr = 1'b1;
        end
        if (op == op_reg_low_plus) begin
          alu_res = regs[ridx] + ram_rdata;  // wraps mod 2^16
        end else if (op == op_reg_low_minus) begin
          alu_res = regs[ridx] - ram_rdata;
        end
      end
      op_ram2reg: begin
        if (reg_bad) begin
          exec_err = err_wrong_reg_num;
        end
      end
      op_exit: exec_exit = 1'b1;
      default: exec_err = err_illegal_opcode;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= st_idle;
      after_map <= st_word_op;
      pc        <= '0;
      instr     <= '0;
      map_laddr <= '0;
      busy      <= 1'b0;
      halted    <= 1'b0;
      error     <= err_none;
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            halted <= 1'b0;  // registers survive a restart
            error  <= err_none;
            if (start_seg >= `SEG_COUNT) begin  // no such segment, stop at once
              halted <= 1'b1;
              error  <= err_wrong_address;
            end else begin
              busy      <= 1'b1;
              pc        <= `WORD_W'(`PROG_START);
              map_laddr <= `WORD_W'(`PROG_START);
              after_map <= st_word_op;
              state     <= st_map_req;
            end
          end
        end
        st_map_req: state <= st_map_wait;
        st_map_wait: begin
          if (map_done && map_miss) begin
            busy   <= 1'b0;
            halted <= 1'b1;
            error  <= err_wrong_address;  // page missing from the chain
            state  <= st_idle;
          end else if (map_done) begin
            state <= after_map;  // RAM read issued this cycle
          end
        end
        st_word_op: begin
          instr     <= ram_rdata;
          map_laddr <= pc + `WORD_W'(1);  // value word follows
          after_map <= st_word_val;
          state     <= st_map_req;
        end
        st_word_val: begin
          if (reg_wr) begin
            regs[ridx] <= alu_res;
          end
          if (exec_err != err_none || exec_exit) begin
            busy   <= 1'b0;
            halted <= 1'b1;
            error  <= exec_err;
            state  <= st_idle;
          end else if (op == op_ram2reg) begin
            map_laddr <= ram_rdata;  // third fetch, pc unchanged
            after_map <= st_word_mem;
            state     <= st_map_req;
          end else begin
            pc        <= target;
            map_laddr <= target;
            after_map <= st_word_op;
            state     <= st_map_req;
          end
        end
        st_word_mem: begin
          regs[ridx] <= ram_rdata;
          pc         <= seq_pc;
          map_laddr  <= seq_pc;
          after_map  <= st_word_op;
          state      <= st_map_req;
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

// File: hw/cpu_ctrl_apb.sv
`timescale 1ns/100ps
`include "paged_cpu_consts.svh"

module cpu_ctrl_apb import cpu_isa_pkg::*; import apb_bus_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  input  apb_req_t              apb_req,
  input  logic                  busy,
  input  logic                  halted,
  input  error_e                error,
  input  logic [`WORD_W-1:0]    reg_rdata,
  output apb_rsp_t              apb_rsp,
  output logic                  start,
  output logic [`SEG_W-1:0]     start_seg,
  output logic [`REG_IDX_W-1:0] reg_ridx,
  output ram_wr_t               ram_wr,
  output mmu_entry_wr_t         mmu_wr
);

  logic [`WORD_W-1:0]     load_ptr;  // next RAM word to load
  logic [`APB_ADDR_W-1:0] off;
  logic                   is_reg;    // inside the register window
  logic                   known;
  logic                   reject;
  logic                   wr_ok;

  assign off      = apb_req.paddr;
  assign is_reg   = (off & `APB_ADDR_W'('hC3)) == `OFF_REG_BASE;  // 0x40..0x7C, word aligned
  assign reg_ridx = off[`REG_IDX_W+1:2];
  assign reject   = !known || (apb_req.pwrite && busy && off != `OFF_CTRL);
  assign wr_ok    = apb_req.psel && apb_req.penable && apb_req.pwrite && !reject;

  always_comb begin
    case (off)
      `OFF_CTRL, `OFF_STATUS, `OFF_RAM_ADDR, `OFF_RAM_DATA,
      `OFF_MMU_ENTRY, `OFF_START_SEG: known = 1'b1;
      default: known = is_reg;
    endcase
  end

  // zero wait states, read data straight from the decode
  always_comb begin
    apb_rsp.pready  = apb_req.psel;
    apb_rsp.pslverr = apb_req.psel && apb_req.penable && reject;
    apb_rsp.prdata  = '0;  // unknown offsets read 0
    case (off)
      `OFF_STATUS:    apb_rsp.prdata = {{(`WORD_W-4){1'b0}}, error, halted, busy};
      `OFF_RAM_ADDR:  apb_rsp.prdata = load_ptr;
      `OFF_START_SEG: apb_rsp.prdata = `WORD_W'(start_seg);
      default: begin
        if (is_reg) begin
          apb_rsp.prdata = reg_rdata;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      start     <= 1'b0;
      start_seg <= '0;
      load_ptr  <= '0;
      ram_wr    <= '0;
      mmu_wr    <= '0;
    end else begin
      start     <= wr_ok && off == `OFF_CTRL && apb_req.pwdata[0] && !busy;
      ram_wr.en <= 1'b0;  // write strobes last one cycle
      mmu_wr.en <= 1'b0;
      if (wr_ok) begin
        case (off)
          `OFF_RAM_ADDR: load_ptr <= apb_req.pwdata;
          `OFF_RAM_DATA: begin
            ram_wr   <= '{en: 1'b1, addr: load_ptr, data: apb_req.pwdata};
            load_ptr <= load_ptr + 1'b1;  // auto-increment for burst loading
          end
          `OFF_MMU_ENTRY: begin
            mmu_wr <= '{en:    1'b1,
                        seg:   apb_req.pwdata[`SEG_W-1:0],
                        next:  apb_req.pwdata[2*`SEG_W-1:`SEG_W],
                        lpage: apb_req.pwdata[2*`SEG_W+`LPAGE_W-1:2*`SEG_W]};
          end
          `OFF_START_SEG: start_seg <= apb_req.pwdata[`SEG_W-1:0];
          default: begin
          end
        endcase
      end
    end
  end

endmodule

// File: hw/paged_cpu_top.sv
`timescale 1ns/100ps
`include "paged_cpu_consts.svh"

module paged_cpu_top import cpu_isa_pkg::*; import apb_bus_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp
);

  logic                   start;
  logic                   busy;
  logic                   halted;
  error_e                 error;
  logic [`SEG_W-1:0]      start_seg;   // level to core and mapper
  logic [`REG_IDX_W-1:0]  reg_ridx;
  logic [`WORD_W-1:0]     reg_rdata;
  ram_wr_t                ram_wr;
  mmu_entry_wr_t          mmu_wr;
  logic                   map_req;
  logic [`WORD_W-1:0]     map_laddr;
  logic                   map_done;
  logic                   map_miss;
  logic [`RAM_ADDR_W-1:0] map_paddr;
  logic [`RAM_ADDR_W-1:0] ram_raddr;
  logic [`WORD_W-1:0]     ram_rdata;

  cpu_ctrl_apb u_cpu_ctrl_apb (
    .clk, .arst_n, .apb_req, .busy, .halted, .error, .reg_rdata,
    .apb_rsp, .start, .start_seg, .reg_ridx, .ram_wr, .mmu_wr
  );

  cpu_core u_cpu_core (
    .clk, .arst_n, .start, .start_seg, .reg_ridx, .map_done, .map_miss, .map_paddr,
    .ram_rdata, .busy, .halted, .error, .reg_rdata, .map_req, .map_laddr, .ram_raddr
  );

  page_mapper u_page_mapper (
    .clk, .arst_n, .start_seg, .mmu_wr, .map_req, .map_laddr,
    .map_done, .map_miss, .map_paddr
  );

  word_ram u_word_ram (
    .clk,
    .ram_wr,
    .raddr (ram_raddr),
    .rdata (ram_rdata)
  );

endmodule

// File: test/paged_cpu_assertions.sv
`timescale 1ns/100ps

module paged_cpu_assertions import cpu_isa_pkg::*; (
  input logic     clk,
  input logic     arst_n,
  input logic     start,
  input logic     busy,
  input logic     halted,
  input error_e   error,
  input ram_wr_t  ram_wr
);

  busy_after_start: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(busy) |-> $past(start))  // only the start pulse launches the core
    else $error("busy rose without a start pulse");

  no_error_while_busy: assert property (@(posedge clk) disable iff (!arst_n)
    busy |-> error == err_none)  // a start clears the last error
    else $error("error code set while the core is running");

  busy_or_halted: assert property (@(posedge clk) disable iff (!arst_n)
    !(busy && halted))
    else $error("core busy and halted at once");

  no_load_while_busy: assert property (@(posedge clk) disable iff (!arst_n)
    ram_wr.en |-> !busy)  // loads only between runs
    else $error("RAM write while the core is busy");

endmodule

bind paged_cpu_top paged_cpu_assertions u_paged_cpu_assertions (.*);

// File: test/paged_cpu_tb.sv
`timescale 1ns/100ps
`include "paged_cpu_consts.svh"

module paged_cpu_tb import apb_bus_pkg::*; ();

  localparam int DRIVE_DLY   = 1;    // inputs move 1 ns after the rising edge
  localparam int MAX_ROWS    = 128;
  localparam int POLL_CYCLES = 40 * 3 * (`SEG_COUNT + 2);  // 40 instructions, 3 fetches each
  localparam logic [7:0] OP_JMP = 8'd1, OP_JMP_MINUS = 8'd6, OP_RAM2REG = 8'd7;
  localparam logic [7:0] OP_NUM2REG = 8'd16, OP_PLUS = 8'd18, OP_MINUS = 8'd20;
  localparam logic [7:0] OP_EXIT = 8'd30;
  localparam logic [1:0] ERR_NONE = 2'd0, ERR_ADDR = 2'd1, ERR_REG = 2'd2, ERR_OPCODE = 2'd3;
  localparam logic [15:0] PAGED_DATA = 16'hBEEF;  // word behind logical 150

  typedef enum {k_write, k_read, k_poll} row_kind_e;

  string       row_name [MAX_ROWS];
  row_kind_e   row_kind [MAX_ROWS];
  logic [7:0]  row_off  [MAX_ROWS];
  logic [15:0] row_data [MAX_ROWS];
  logic [15:0] row_exp  [MAX_ROWS];  // read data or final status
  logic        row_err  [MAX_ROWS];  // expected pslverr
  int          n_rows = 0;
  int          n_polls = 0;
  int          errors = 0;
  int          cycles = 0;
  int          cycle_limit = 0;
  logic        clk = 1'b0;
  logic        arst_n;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;

  always #2 clk = ~clk;  // 4 ns period

  paged_cpu_top u_paged_cpu_top (.clk, .arst_n, .apb_req, .apb_rsp);

  function automatic logic [15:0] instr_word(input logic [7:0] op, input logic [7:0] operand);
    return {op, operand};  // opcode high byte, register low byte
  endfunction

  function automatic logic [15:0] status_word(input logic busy, input logic halted,
                                              input logic [1:0] err);
    return {12'd0, err, halted, busy};
  endfunction

  function automatic logic [15:0] chain_word(input int seg, input int next, input int lpage);
    return 16'(seg) | (16'(next) << 3) | (16'(lpage) << 6);
  endfunction

  function automatic logic [7:0] reg_off(input int n);
    return 8'(`OFF_REG_BASE + 4 * n);
  endfunction

  task automatic add_row(input string name, input row_kind_e kind, input logic [7:0] off,
                         input logic [15:0] data, input logic [15:0] exp, input logic err);
    row_name[n_rows] = name;
    row_kind[n_rows] = kind;
    row_off[n_rows]  = off;
    row_data[n_rows] = data;
    row_exp[n_rows]  = exp;
    row_err[n_rows]  = err;
    if (kind == k_poll) n_polls++;
    n_rows++;
  endtask

  task automatic set_ptr(input string name, input int addr);
    add_row({name, "_ptr"}, k_write, `OFF_RAM_ADDR, 16'(addr), 16'd0, 1'b0);
  endtask

  task automatic put_instr(input string name, input logic [7:0] op, input logic [7:0] operand,
                           input logic [15:0] value);
    add_row({name, "_op"}, k_write, `OFF_RAM_DATA, instr_word(op, operand), 16'd0, 1'b0);
    add_row({name, "_val"}, k_write, `OFF_RAM_DATA, value, 16'd0, 1'b0);
  endtask

  task automatic start_and_wait(input string name, input logic [1:0] err);
    add_row({name, "_start"}, k_write, `OFF_CTRL, 16'd1, 16'd0, 1'b0);
    add_row({name, "_status"}, k_poll, `OFF_STATUS, 16'd0, status_word(1'b0, 1'b1, err), 1'b0);
  endtask

  task automatic error_case(input string name, input logic [7:0] op, input logic [7:0] operand,
                            input logic [15:0] value, input logic [1:0] err);
    set_ptr(name, `PROG_START);
    put_instr(name, op, operand, value);
    start_and_wait(name, err);
  endtask

  task automatic build_table();
    add_row("reset_status", k_read, `OFF_STATUS, 16'd0, 16'd0, 1'b0);
    for (int n = 0; n < `REG_COUNT; n++) begin
      add_row($sformatf("reset_r%0d", n), k_read, reg_off(n), 16'd0, 16'd0, 1'b0);
    end
    set_ptr("arith", `PROG_START);
    put_instr("arith", OP_NUM2REG, 8'd2, 16'd3);
    put_instr("arith", OP_PLUS, 8'd2, 16'd5);
    put_instr("arith", OP_MINUS, 8'd2, 16'd1);
    put_instr("arith", OP_EXIT, 8'd0, 16'd0);
    start_and_wait("arith", ERR_NONE);
    add_row("arith_r2", k_read, reg_off(2), 16'd0, 16'(3 + 5 - 1), 1'b0);
    add_row("chain_seg0", k_write, `OFF_MMU_ENTRY, chain_word(0, 5, 0), 16'd0, 1'b0);
    add_row("chain_seg5", k_write, `OFF_MMU_ENTRY, chain_word(5, 2, 1), 16'd0, 1'b0);
    add_row("chain_seg2", k_write, `OFF_MMU_ENTRY, chain_word(2, 2, 2), 16'd0, 1'b0);  // self link
    add_row("start_seg", k_write, `OFF_START_SEG, 16'd0, 16'd0, 1'b0);
    set_ptr("paged", `PROG_START);
    put_instr("paged", OP_JMP, 8'd0, 16'(`PAGE_WORDS + 2));  // logical 72, page 1
    set_ptr("paged_p1", 5 * `PAGE_WORDS + 2);  // page 1 sits in segment 5
    put_instr("paged_p1", OP_RAM2REG, 8'd3, 16'(2 * `PAGE_WORDS + 10));  // logical 150
    put_instr("paged_p1", OP_EXIT, 8'd0, 16'd0);
    set_ptr("paged_p2", 2 * `PAGE_WORDS + 10);  // page 2 sits in segment 2
    add_row("paged_data", k_write, `OFF_RAM_DATA, PAGED_DATA, 16'd0, 1'b0);
    start_and_wait("paged", ERR_NONE);
    add_row("paged_r3", k_read, reg_off(3), 16'd0, PAGED_DATA, 1'b0);
    error_case("odd_jmp", OP_JMP, 8'd0, 16'd73, ERR_ADDR);
    error_case("reg20", OP_NUM2REG, 8'd20, 16'd1, ERR_REG);
    error_case("opcode99", 8'd99, 8'd0, 16'd0, ERR_OPCODE);
    error_case("page4", OP_JMP, 8'd0, 16'(4 * `PAGE_WORDS), ERR_ADDR);  // not in the chain
    error_case("jmp_minus", OP_JMP_MINUS, 8'd0, 16'd5, ERR_ADDR);  // 48 - 10 lands on 38
    add_row("regs_kept", k_read, reg_off(2), 16'd0, 16'd7, 1'b0);
    add_row("busy_start", k_write, `OFF_CTRL, 16'd1, 16'd0, 1'b0);
    add_row("busy_ram_data", k_write, `OFF_RAM_DATA, 16'hDEAD, 16'd0, 1'b1);  // right after start
    add_row("busy_status", k_poll, `OFF_STATUS, 16'd0, status_word(1'b0, 1'b1, ERR_ADDR), 1'b0);
    add_row("busy_ptr", k_read, `OFF_RAM_ADDR, 16'd0, 16'(`PROG_START + 2), 1'b0);  // unchanged
    add_row("bad_offset", k_read, 8'h30, 16'd0, 16'd0, 1'b1);
  endtask

  task automatic compare_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  // setup cycle then enable cycle, response sampled mid enable
  task automatic apb_access(input logic write, input logic [7:0] off, input logic [15:0] wdata,
                            output logic [15:0] rdata, output logic slverr, output logic ready);
    @(posedge clk);
    #DRIVE_DLY;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = off;
    apb_req.pwdata  = wdata;
    @(posedge clk);
    #DRIVE_DLY;
    apb_req.penable = 1'b1;
    @(negedge clk);
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    ready  = apb_rsp.pready;
  endtask

  task automatic poll_halted(input string name, input logic [15:0] exp);
    logic [15:0] rdata;
    logic        slverr;
    logic        ready;
    int          reads;
    apb_access(1'b0, `OFF_STATUS, 16'd0, rdata, slverr, ready);
    reads = 1;
    while (!rdata[1] && reads < POLL_CYCLES / 2) begin  // two cycles per read
      apb_access(1'b0, `OFF_STATUS, 16'd0, rdata, slverr, ready);
      reads++;
    end
    if (!rdata[1]) begin
      $display("ERROR %s: core did not halt within %0d status reads", name, reads);
      errors++;
    end else begin
      compare_value(name, exp, rdata);
    end
  endtask

  initial begin
    logic [15:0] rdata;
    logic        slverr;
    logic        ready;
    arst_n  = 1'b0;
    apb_req = '0;
    build_table();
    cycle_limit = n_rows * 4 + n_polls * POLL_CYCLES + 16;  // 16 covers reset and drain
    repeat (3) @(posedge clk);
    #DRIVE_DLY;
    arst_n = 1'b1;
    for (int i = 0; i < n_rows; i++) begin
      if (row_kind[i] == k_poll) begin
        poll_halted(row_name[i], row_exp[i]);
      end else begin
        apb_access(row_kind[i] == k_write, row_off[i], row_data[i], rdata, slverr, ready);
        if (row_kind[i] == k_read) compare_value(row_name[i], row_exp[i], rdata);
        compare_value({row_name[i], "_pslverr"}, 16'(row_err[i]), 16'(slverr));
        compare_value({row_name[i], "_pready"}, 16'd1, 16'(ready));  // zero wait states
      end
    end
    @(posedge clk);
    #DRIVE_DLY;
    apb_req = '0;
    @(posedge clk);
    $display("paged_cpu_tb: %0d rows, %0d errors", n_rows, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    wait (cycle_limit > 0);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d clock cycles", cycle_limit);
    $display("test failed");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+hw
hw/cpu_isa_pkg.sv
hw/apb_bus_pkg.sv
hw/word_ram.sv
hw/page_mapper.sv
hw/cpu_core.sv
hw/cpu_ctrl_apb.sv
hw/paged_cpu_top.sv
test/paged_cpu_assertions.sv
test/paged_cpu_tb.sv
